// File: Makefile
# Verilator build and run for the mesh router testbench

VERILATOR  ?= verilator
TOP        ?= mesh_router_tb
FILELIST   ?= sim.f
OBJ_DIR    ?= obj_dir
LOG        ?= sim.log
VFLAGS     ?= --binary --assert -Wno-fatal
LINT_FLAGS ?= --lint-only --timing
SOURCES    := $(wildcard source/*.sv source/*.svh test/*.sv)

.PHONY: all run build lint clean

all: run

build: $(OBJ_DIR)/V$(TOP)

$(OBJ_DIR)/V$(TOP): $(FILELIST) $(SOURCES)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(OBJ_DIR) -f $(FILELIST)

run: build
	-./$(OBJ_DIR)/V$(TOP) > $(LOG) 2>&1
	@cat $(LOG)
	@if grep -q "ERRORS FOUND" $(LOG); then echo "simulation failed"; exit 1; fi
	@if ! grep -q "NO ERRORS" $(LOG); then echo "simulation ended without a verdict"; exit 1; fi
	@echo "simulation passed"

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

// File: sim.f
+incdir+source
source/noc_pkg.sv
source/flit_queue.sv
source/route_compute.sv
source/input_port.sv
source/switch_alloc.sv
source/mesh_router.sv
test/mesh_router_props.sv
test/mesh_router_tb.sv

// File: source/flit_queue.sv
`timescale 1ns/1ps
`default_nettype none

`include "noc_params.svh"

module flit_queue #(
    parameter type entry_t = logic [7:0]
) (
    input  logic                                   clk,
    input  logic                                   rst,
    input  logic                                   push,
    input  entry_t                                 push_data,
    input  logic                                   pop,
    output entry_t                                 head,
    output logic                                   head_valid,
    output logic [$clog2(`NOC_QUEUE_DEPTH + 1)-1:0] count
);

    localparam int depth = `NOC_QUEUE_DEPTH;
    localparam int ptr_w = $clog2(depth);
    localparam int cnt_w = $clog2(depth + 1);
    localparam logic [ptr_w-1:0] last_slot = ptr_w'(depth - 1);

    // storage, no reset needed
    entry_t mem [depth];

    logic [ptr_w-1:0] rd_ptr;
    logic [ptr_w-1:0] wr_ptr;

    //////////////////////////////
    // write side
    //////////////////////////////

    always_ff @(posedge clk) begin
        if (push) begin
            mem[wr_ptr] <= push_data;
        end
    end

    // pointers wrap explicitly, depth need not be a power of two
    always_ff @(posedge clk) begin
        if (rst) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
        end else begin
            if (push) begin
                wr_ptr <= (wr_ptr == last_slot) ? '0 : wr_ptr + 1'b1;
            end
            if (pop) begin
                rd_ptr <= (rd_ptr == last_slot) ? '0 : rd_ptr + 1'b1;
            end
        end
    end

    // occupancy, push and pop together hold it
    always_ff @(posedge clk) begin
        if (rst) begin
            count <= '0;
        end else begin
            case ({push, pop})
                2'b10:   count <= count + cnt_w'(1);
                2'b01:   count <= count - cnt_w'(1);
                default: count <= count;
            endcase
        end
    end

    // head shows the oldest entry, first write appears next cycle
    assign head       = mem[rd_ptr];
    assign head_valid = (count != '0);

endmodule

`default_nettype wire

// File: source/input_port.sv
`timescale 1ns/1ps
`default_nettype none

`include "noc_params.svh"

module input_port #(
    parameter int cur_x = 0,
    parameter int cur_y = 0
) (
    input  logic                  clk,
    input  logic                  rst,
    input  noc_pkg::link_t        link_in,
    output logic                  credit_out,
    input  logic                  pop,
    output noc_pkg::routed_flit_t head,
    output logic                  head_valid
);

    import noc_pkg::*;

    localparam int cnt_w = $clog2(`NOC_QUEUE_DEPTH + 1);
    localparam logic [cnt_w-1:0] full_level = cnt_w'(`NOC_QUEUE_DEPTH);

    flit_t             in_head;
    logic              in_valid;
    logic              deq;
    routed_flit_t      rc_out;
    logic              rc_valid;
    logic [cnt_w-1:0]  sw_count;
    logic [cnt_w-1:0]  slots_used;

    //////////////////////////////
    // input queue
    //////////////////////////////

    // upstream only sends with a credit, so no full check here
    flit_queue #(.entry_t(flit_t)) in_q (
        .clk        (clk),
        .rst        (rst),
        .push       (link_in.valid),
        .push_data  (link_in.flit),
        .pop        (deq),
        .head       (in_head),
        .head_valid (in_valid),
        .count      ()
    );

    // pre-switch slots taken, incl the flit inside route compute
    assign slots_used = sw_count + cnt_w'(rc_valid);
    assign deq        = in_valid && (slots_used < full_level);
    // every dequeue frees one upstream slot
    assign credit_out = deq;

    //////////////////////////////
    // route, then pre-switch queue
    //////////////////////////////

    route_compute #(.cur_x(cur_x), .cur_y(cur_y)) rc_i (
        .clk        (clk),
        .rst        (rst),
        .flit_in    (in_head),
        .valid_in   (deq),
        .routed_out (rc_out),
        .valid_out  (rc_valid)
    );

    flit_queue #(.entry_t(routed_flit_t)) sw_q (
        .clk        (clk),
        .rst        (rst),
        .push       (rc_valid),
        .push_data  (rc_out),
        .pop        (pop),
        .head       (head),
        .head_valid (head_valid),
        .count      (sw_count)
    );

endmodule

`default_nettype wire

// File: source/mesh_router.sv
`timescale 1ns/1ps
`default_nettype none

`include "noc_params.svh"

module mesh_router #(
    parameter int cur_x = 0,
    parameter int cur_y = 0
) (
    input  logic                      clk,
    input  logic                      rst,
    input  noc_pkg::link_t            in_link [`NOC_NUM_PORTS],
    output logic [`NOC_NUM_PORTS-1:0] in_credit,
    output noc_pkg::link_t            out_link [`NOC_NUM_PORTS],
    input  logic [`NOC_NUM_PORTS-1:0] out_credit
);

    import noc_pkg::*;

    // pre-switch heads towards the allocator
    routed_flit_t                heads [`NOC_NUM_PORTS];
    logic [`NOC_NUM_PORTS-1:0]   head_valid;
    logic [`NOC_NUM_PORTS-1:0]   pops;

    //////////////////////////////
    // one pipeline per input port
    //////////////////////////////

    // port 0 is injection from the kernel
    genvar p;
    generate
        for (p = 0; p < `NOC_NUM_PORTS; p++) begin : g_port
            input_port #(.cur_x(cur_x), .cur_y(cur_y)) port_i (
                .clk        (clk),
                .rst        (rst),
                .link_in    (in_link[p]),
                .credit_out (in_credit[p]),
                .pop        (pops[p]),
                .head       (heads[p]),
                .head_valid (head_valid[p])
            );
        end
    endgenerate

    // output 0 is ejection to the kernel
    switch_alloc sw_i (
        .clk        (clk),
        .rst        (rst),
        .heads      (heads),
        .head_valid (head_valid),
        .pops       (pops),
        .out_link   (out_link),
        .out_credit (out_credit)
    );

endmodule

`default_nettype wire

// File: source/noc_params.svh
`ifndef NOC_PARAMS_SVH
`define NOC_PARAMS_SVH

//////////////////////////////
// flit field widths
//////////////////////////////

// one mesh coordinate, x or y
`define NOC_COORD_W 3
// identification tag carried with each flit
`define NOC_TAG_W 8
`define NOC_PAYLOAD_W 32

//////////////////////////////
// buffering and ports
//////////////////////////////

// queue entries, also the credits an output starts with
`define NOC_QUEUE_DEPTH 4
// must hold 0 .. NOC_QUEUE_DEPTH
`define NOC_CREDIT_W 3
// local, xpos, xneg, ypos, yneg
`define NOC_NUM_PORTS 5

`endif

// File: source/noc_pkg.sv
`default_nettype none

`include "noc_params.svh"

package noc_pkg;

    //////////////////////////////
    // ports
    //////////////////////////////

    // fixed order, also the index of every port array
    typedef enum logic [2:0] {
        port_local,
        port_xpos,
        port_xneg,
        port_ypos,
        port_yneg
    } port_e;

    //////////////////////////////
    // flit formats
    //////////////////////////////

    // destination first, then source, tag and data
    typedef struct packed {
        logic [`NOC_COORD_W-1:0]   dst_x;
        logic [`NOC_COORD_W-1:0]   dst_y;
        logic [`NOC_COORD_W-1:0]   src_x;
        logic [`NOC_COORD_W-1:0]   src_y;
        logic [`NOC_TAG_W-1:0]     tag;
        logic [`NOC_PAYLOAD_W-1:0] payload;
    } flit_t;

    // flit plus the output picked by route compute
    typedef struct packed {
        port_e dir;
        flit_t flit;
    } routed_flit_t;

    // what travels on a router port
    typedef struct packed {
        logic  valid;
        flit_t flit;
    } link_t;

endpackage

`default_nettype wire

// File: source/route_compute.sv
`timescale 1ns/1ps
`default_nettype none

`include "noc_params.svh"

module route_compute #(
    parameter int cur_x = 0,
    parameter int cur_y = 0
) (
    input  logic                 clk,
    input  logic                 rst,
    input  noc_pkg::flit_t       flit_in,
    input  logic                 valid_in,
    output noc_pkg::routed_flit_t routed_out,
    output logic                 valid_out
);

    import noc_pkg::*;

    // this router's own place in the mesh
    localparam logic [`NOC_COORD_W-1:0] here_x = cur_x[`NOC_COORD_W-1:0];
    localparam logic [`NOC_COORD_W-1:0] here_y = cur_y[`NOC_COORD_W-1:0];

    port_e next_dir;

    // dimension order, x resolved before y
    always_comb begin
        if (flit_in.dst_x != here_x) begin
            next_dir = (flit_in.dst_x > here_x) ? port_xpos : port_xneg;
        end else if (flit_in.dst_y != here_y) begin
            next_dir = (flit_in.dst_y > here_y) ? port_ypos : port_yneg;
        end else begin
            // arrived, eject to the kernel
            next_dir = port_local;
        end
    end

    // decision and flit leave together one cycle later
    always_ff @(posedge clk) begin
        if (valid_in) begin
            routed_out.dir  <= next_dir;
            routed_out.flit <= flit_in;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            valid_out <= 1'b0;
        end else begin
            valid_out <= valid_in;
        end
    end

endmodule

`default_nettype wire

// File: source/switch_alloc.sv
`timescale 1ns/1ps
`default_nettype none

`include "noc_params.svh"

module switch_alloc (
    input  logic                      clk,
    input  logic                      rst,
    input  noc_pkg::routed_flit_t     heads [`NOC_NUM_PORTS],
    input  logic [`NOC_NUM_PORTS-1:0] head_valid,
    output logic [`NOC_NUM_PORTS-1:0] pops,
    output noc_pkg::link_t            out_link [`NOC_NUM_PORTS],
    input  logic [`NOC_NUM_PORTS-1:0] out_credit
);

    import noc_pkg::*;

    localparam int n  = `NOC_NUM_PORTS;
    localparam int cw = `NOC_CREDIT_W;

    // credits held for each downstream queue
    logic [cw-1:0] credit [n];
    // grant[o][i], input i wins output o
    logic [n-1:0]  grant [n];
    logic [n-1:0]  out_valid_q;
    flit_t         out_flit_q [n];

    genvar o;
    generate
        for (o = 0; o < n; o++) begin : g_out
            logic [n-1:0]  req;
            logic [2:0]    rr;
            logic [2:0]    sel;
            logic          found;
            logic [cw-1:0] in_use;
            logic          send_ok;

            // inputs whose head names this output
            always_comb begin
                for (int i = 0; i < n; i++) begin
                    req[i] = head_valid[i] && (heads[i].dir == port_e'(o));
                end
            end

            // round robin search starting at rr
            always_comb begin
                int idx;
                idx   = 0;
                found = 1'b0;
                sel   = '0;
                for (int k = 0; k < n; k++) begin
                    idx = int'(rr) + k;
                    if (idx >= n) begin
                        idx = idx - n;
                    end
                    if (!found && req[idx]) begin
                        found = 1'b1;
                        sel   = 3'(idx);
                    end
                end
            end

            // flit on the link still owns one credit this cycle
            assign in_use  = cw'(out_valid_q[o]);
            assign send_ok = found && (credit[o] > in_use);

            always_comb begin
                grant[o] = '0;
                if (send_ok) begin
                    grant[o][sel] = 1'b1;
                end
            end

            //////////////////////////////
            // output and credit state
            //////////////////////////////

            always_ff @(posedge clk) begin
                if (rst) begin
                    rr             <= '0;
                    out_valid_q[o] <= 1'b0;
                end else begin
                    out_valid_q[o] <= send_ok;
                    // winner drops to lowest priority
                    if (send_ok) begin
                        rr <= (sel == 3'(n - 1)) ? '0 : sel + 1'b1;
                    end
                end
            end

            // spent when the flit is on the link, back on out_credit
            always_ff @(posedge clk) begin
                if (rst) begin
                    credit[o] <= cw'(`NOC_QUEUE_DEPTH);
                end else begin
                    case ({out_valid_q[o], out_credit[o]})
                        2'b10:   credit[o] <= credit[o] - 1'b1;
                        2'b01:   credit[o] <= credit[o] + 1'b1;
                        default: credit[o] <= credit[o];
                    endcase
                end
            end

            // crossbar into the output register
            always_ff @(posedge clk) begin
                if (send_ok) begin
                    out_flit_q[o] <= heads[sel].flit;
                end
            end

            assign out_link[o] = '{valid: out_valid_q[o], flit: out_flit_q[o]};
        end
    endgenerate

    // each head names one output, so one grant per input at most
    always_comb begin
        pops = '0;
        for (int oo = 0; oo < n; oo++) begin
            pops = pops | grant[oo];
        end
    end

endmodule

`default_nettype wire

// File: test/mesh_router_props.sv
`timescale 1ns/1ps
`default_nettype none

`include "noc_params.svh"

module mesh_router_props (
    input logic                      clk,
    input logic                      rst,
    input logic [`NOC_NUM_PORTS-1:0] out_valid,
    input logic [`NOC_NUM_PORTS-1:0] out_credit,
    input logic [`NOC_CREDIT_W-1:0]  credit [`NOC_NUM_PORTS]
);

    // assertion failures so far
    int fail_count = 0;

    //////////////////////////////
    // per output credit rules
    //////////////////////////////

    genvar o;
    generate
        for (o = 0; o < `NOC_NUM_PORTS; o++) begin : g_chk
            // a flit on the link was paid for
            valid_has_credit: assert property (@(posedge clk) disable iff (rst)
                out_valid[o] |-> (credit[o] != '0))
                else begin
                    $error("output %0d valid while its credit counter is zero", o);
                    fail_count++;
                end

            // never more credits than downstream slots
            credit_in_range: assert property (@(posedge clk) disable iff (rst)
                int'(credit[o]) <= `NOC_QUEUE_DEPTH)
                else begin
                    $error("output %0d credit counter above queue depth", o);
                    fail_count++;
                end
        end
    endgenerate

    //////////////////////////////
    // reset behavior
    //////////////////////////////

    // neighbors stay quiet in reset
    quiet_credit_in_reset: assert property (@(posedge clk)
        rst |-> (out_credit == '0))
        else begin
            $error("credit returned while reset is active");
            fail_count++;
        end

    // outputs idle after a reset edge
    idle_after_reset: assert property (@(posedge clk)
        rst |=> (out_valid == '0))
        else begin
            $error("output valid right after a reset edge");
            fail_count++;
        end

endmodule

bind switch_alloc mesh_router_props props_i (
    .clk        (clk),
    .rst        (rst),
    .out_valid  (out_valid_q),
    .out_credit (out_credit),
    .credit     (credit)
);

`default_nettype wire

// File: test/mesh_router_tb.sv
`timescale 1ns/1ps
`default_nettype none

`include "noc_params.svh"

module mesh_router_tb;

    import noc_pkg::*;

    localparam int n_ports      = `NOC_NUM_PORTS;
    localparam int depth        = `NOC_QUEUE_DEPTH;
    localparam int coord_w      = `NOC_COORD_W;
    localparam int num_rows     = 16;
    localparam int here_x       = 2;
    localparam int here_y       = 2;
    localparam int clk_period   = 20;
    localparam int stall_cycles = 10 * depth;
    localparam int watch_cycles = num_rows * 40 + 200;

    // one stimulus row, exp_port worked out by hand from x then y
    typedef struct packed {
        port_e                in_port;
        logic [coord_w-1:0]   dst_x;
        logic [coord_w-1:0]   dst_y;
        logic [`NOC_TAG_W-1:0] tag;
        port_e                exp_port;
    } stim_t;

    logic               clk = 1'b0;
    logic               rst = 1'b1;
    link_t              in_link [n_ports] = '{default: '0};
    logic [n_ports-1:0] in_credit;
    link_t              out_link [n_ports];
    logic [n_ports-1:0] out_credit = '0;

    // router sits at (2,2)
    stim_t stim [num_rows] = '{
        '{port_local, 3'd4, 3'd1, 8'h01, port_xpos},
        '{port_xneg,  3'd3, 3'd2, 8'h02, port_xpos},
        '{port_ypos,  3'd5, 3'd0, 8'h03, port_xpos},
        '{port_yneg,  3'd3, 3'd3, 8'h04, port_xpos},
        '{port_xpos,  3'd0, 3'd2, 8'h05, port_xneg},
        '{port_local, 3'd2, 3'd4, 8'h06, port_ypos},
        '{port_xneg,  3'd2, 3'd2, 8'h07, port_local},
        '{port_ypos,  3'd2, 3'd1, 8'h08, port_yneg},
        '{port_yneg,  3'd2, 3'd6, 8'h09, port_ypos},
        '{port_xpos,  3'd2, 3'd2, 8'h0a, port_local},
        '{port_local, 3'd3, 3'd0, 8'h0b, port_xpos},
        '{port_yneg,  3'd7, 3'd7, 8'h0c, port_xpos},
        '{port_xpos,  3'd1, 3'd5, 8'h0d, port_xneg},
        '{port_local, 3'd2, 3'd0, 8'h0e, port_yneg},
        '{port_ypos,  3'd0, 3'd0, 8'h0f, port_xneg},
        '{port_local, 3'd2, 3'd2, 8'h10, port_local}
    };

    // scoreboard, one expected flit per row
    flit_t       exp_flit [num_rows];
    logic        got [num_rows];
    int          recv_total;
    int          recv_port [n_ports];
    // neighbor models
    int          next_row [n_ports];
    int          up_credit [n_ports];
    int          sent_cnt [n_ports];
    int          credit_cnt [n_ports];
    int          down_pending [n_ports];
    logic        hold_xpos;
    logic [15:0] lfsr_state;
    int          errors;

    mesh_router #(.cur_x(here_x), .cur_y(here_y)) dut_i (
        .clk        (clk),
        .rst        (rst),
        .in_link    (in_link),
        .in_credit  (in_credit),
        .out_link   (out_link),
        .out_credit (out_credit)
    );

    always #(clk_period / 2) clk = ~clk;

    //////////////////////////////
    // helpers
    //////////////////////////////

    task automatic report_error(input string msg);
        errors++;
        $display("Error at %0d ns: %s", $time, msg);
    endtask

    // 16 bit fibonacci, taps 16 14 13 11
    function automatic logic [15:0] lfsr_next(input logic [15:0] s);
        return {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]};
    endfunction

    // one step per payload bit
    task automatic draw_payload(output logic [`NOC_PAYLOAD_W-1:0] value);
        value = '0;
        for (int b = 0; b < `NOC_PAYLOAD_W; b++) begin
            lfsr_state = lfsr_next(lfsr_state);
            value      = {value[`NOC_PAYLOAD_W-2:0], lfsr_state[0]};
        end
    endtask

    // source is the neighbor behind the input port
    task automatic set_source(input port_e p, inout flit_t f);
        f.src_x = coord_w'(here_x);
        f.src_y = coord_w'(here_y);
        case (p)
            port_xpos: f.src_x = coord_w'(here_x + 1);
            port_xneg: f.src_x = coord_w'(here_x - 1);
            port_ypos: f.src_y = coord_w'(here_y + 1);
            port_yneg: f.src_y = coord_w'(here_y - 1);
            default:   ;
        endcase
    endtask

    // top tag bit marks the second pass
    task automatic start_pass(input logic second);
        flit_t f;
        recv_total = 0;
        for (int p = 0; p < n_ports; p++) begin
            next_row[p]  = 0;
            recv_port[p] = 0;
        end
        for (int r = 0; r < num_rows; r++) begin
            f.dst_x = stim[r].dst_x;
            f.dst_y = stim[r].dst_y;
            set_source(stim[r].in_port, f);
            f.tag                = stim[r].tag;
            f.tag[`NOC_TAG_W-1]  = second;
            draw_payload(f.payload);
            exp_flit[r] = f;
            got[r]      = 1'b0;
        end
    endtask

    function automatic int find_row(input logic [`NOC_TAG_W-1:0] tag);
        for (int r = 0; r < num_rows; r++) begin
            if (exp_flit[r].tag == tag) begin
                return r;
            end
        end
        return -1;
    endfunction

    task automatic check_arrival(input int o, input flit_t f);
        int row;
        row = find_row(f.tag);
        if (row < 0) begin
            report_error($sformatf("output %0d delivered unknown tag %0h", o, f.tag));
        end else if (got[row]) begin
            report_error($sformatf("tag %0h delivered twice", f.tag));
        end else begin
            if (int'(stim[row].exp_port) != o) begin
                report_error($sformatf("tag %0h left at output %0d, expected %0d",
                    f.tag, o, int'(stim[row].exp_port)));
            end
            if (f != exp_flit[row]) begin
                report_error($sformatf("tag %0h content %h, expected %h",
                    f.tag, f, exp_flit[row]));
            end
            // same input, same output, table order
            for (int r = 0; r < row; r++) begin
                if (stim[r].in_port == stim[row].in_port &&
                    stim[r].exp_port == stim[row].exp_port && !got[r]) begin
                    report_error($sformatf("tag %0h overtook tag %0h", f.tag, stim[r].tag));
                end
            end
            got[row] = 1'b1;
            recv_total++;
            recv_port[o]++;
        end
    endtask

    //////////////////////////////
    // one clock of neighbor traffic
    //////////////////////////////

    task automatic run_cycle();
        @(negedge clk);
        // credits back from router inputs
        for (int p = 0; p < n_ports; p++) begin
            if (in_credit[p]) begin
                credit_cnt[p]++;
                up_credit[p]++;
                if (up_credit[p] > depth) begin
                    report_error($sformatf("input %0d returned more credits than flits", p));
                end
            end
        end
        // downstream takes flits, credits back one per cycle
        for (int o = 0; o < n_ports; o++) begin
            if (out_link[o].valid) begin
                check_arrival(o, out_link[o].flit);
                down_pending[o]++;
                if (down_pending[o] > depth) begin
                    report_error($sformatf("output %0d sent without a credit", o));
                end
            end
            out_credit[o] = 1'b0;
            if (down_pending[o] > 0 && !(hold_xpos && o == int'(port_xpos))) begin
                out_credit[o] = 1'b1;
                down_pending[o]--;
            end
        end
        // upstream, next row of each port while a credit lasts
        for (int p = 0; p < n_ports; p++) begin
            in_link[p].valid = 1'b0;
            while (next_row[p] < num_rows && int'(stim[next_row[p]].in_port) != p) begin
                next_row[p]++;
            end
            if (next_row[p] < num_rows && up_credit[p] > 0) begin
                in_link[p].valid = 1'b1;
                in_link[p].flit  = exp_flit[next_row[p]];
                up_credit[p]--;
                sent_cnt[p]++;
                next_row[p]++;
            end
        end
    endtask

    task automatic check_idle_outputs();
        for (int p = 0; p < n_ports; p++) begin
            if (out_link[p].valid !== 1'b0) begin
                report_error($sformatf("output %0d valid after reset", p));
            end
        end
        if (in_credit !== '0) begin
            report_error($sformatf("in_credit %b after reset", in_credit));
        end
    endtask

    // every flit has left, so every dequeue happened
    task automatic check_credit_balance();
        for (int p = 0; p < n_ports; p++) begin
            if (credit_cnt[p] != sent_cnt[p]) begin
                report_error($sformatf("input %0d returned %0d credits for %0d flits",
                    p, credit_cnt[p], sent_cnt[p]));
            end
        end
    endtask

    function automatic logic downstream_idle();
        for (int o = 0; o < n_ports; o++) begin
            if (down_pending[o] != 0) begin
                return 1'b0;
            end
        end
        return 1'b1;
    endfunction

    //////////////////////////////
    // test sequence
    //////////////////////////////

    initial begin
        int xpos_cap;
        int assert_fails;
        errors     = 0;
        hold_xpos  = 1'b0;
        recv_total = 0;
        lfsr_state = 16'd82;
        for (int p = 0; p < n_ports; p++) begin
            next_row[p]     = num_rows;
            up_credit[p]    = depth;
            sent_cnt[p]     = 0;
            credit_cnt[p]   = 0;
            down_pending[p] = 0;
            recv_port[p]    = 0;
        end
        for (int r = 0; r < num_rows; r++) begin
            exp_flit[r] = '0;
            got[r]      = 1'b1;
        end
        // flits that the held xpos output can still take
        xpos_cap = 0;
        for (int r = 0; r < num_rows; r++) begin
            if (stim[r].exp_port == port_xpos) begin
                xpos_cap++;
            end
        end
        if (xpos_cap > depth) begin
            xpos_cap = depth;
        end

        repeat (2) @(posedge clk);
        @(negedge clk);
        rst = 1'b0;
        check_idle_outputs();
        run_cycle();
        check_idle_outputs();

        // free flow, four inputs meet at xpos
        start_pass(1'b0);
        while (recv_total < num_rows) begin
            run_cycle();
        end
        check_credit_balance();
        while (!downstream_idle()) begin
            run_cycle();
        end

        // xpos neighbor holds its credits back
        hold_xpos = 1'b1;
        start_pass(1'b1);
        while (recv_port[port_xpos] < xpos_cap) begin
            run_cycle();
        end
        repeat (stall_cycles) run_cycle();
        if (recv_port[port_xpos] > depth) begin
            report_error($sformatf("%0d flits on held xpos output", recv_port[port_xpos]));
        end
        hold_xpos = 1'b0;
        while (recv_total < num_rows) begin
            run_cycle();
        end
        check_credit_balance();
        while (!downstream_idle()) begin
            run_cycle();
        end

        // quiet window, a late or repeated flit shows up here
        repeat (stall_cycles) run_cycle();

        assert_fails = dut_i.sw_i.props_i.fail_count;
        $display("run complete with %0d check errors and %0d assertion failures",
            errors, assert_fails);
        if (errors == 0 && assert_fails == 0) begin
            $display("NO ERRORS");
        end else begin
            $display("ERRORS FOUND");
        end
        $finish;
    end

    // watchdog sized from the table
    initial begin
        #(watch_cycles * clk_period);
        $display("timeout, traffic still running after %0d cycles, %0d errors so far",
            watch_cycles, errors);
        $display("ERRORS FOUND");
        $finish;
    end

endmodule

`default_nettype wire
